/* hw/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc value after reset, the first word fetched.
`define FETCH_RESET_VECTOR 32'h0000_0200

// width of one increment group in the pc incrementer.
`define FETCH_INC_GROUP 4

// instruction and address width.
`define FETCH_WORD_BITS 32

`endif

/* hw/mem_if_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package mem_if_pkg;

    // byte address driven on the instruction memory port.
    typedef logic [`FETCH_WORD_BITS-1:0] mem_addr_t;

    // one instruction word as returned by memory.
    typedef logic [`FETCH_WORD_BITS-1:0] mem_word_t;

endpackage

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // program counter, byte addressed.
    typedef logic [`FETCH_WORD_BITS-1:0] pc_t;

    // pc without the two byte-offset bits.
    typedef logic [`FETCH_WORD_BITS-3:0] word_index_t;

endpackage

`default_nettype wire

/* hw/word_incrementer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module word_incrementer
    import fetch_pkg::*;
(
    input  word_index_t value,
    output word_index_t result
);

    localparam int WIDTH   = $bits(word_index_t);
    localparam int GRP     = `FETCH_INC_GROUP;
    localparam int GROUPS  = WIDTH / GRP;
    localparam int REM_LSB = GROUPS * GRP;

    // per group: incremented value, and whether the group is all ones.
    logic [GRP-1:0]    grp_inc [GROUPS];
    logic [GRP:0]      grp_and [GROUPS];
    logic [GROUPS-1:0] grp_carry;

    // carry into the group above.
    logic [GROUPS-1:0] carry_chain;

    genvar g;
    genvar b;
    generate
        for (g = 0; g < GROUPS; g++)
        begin : gen_group
            assign grp_and[g][0] = 1'b1;
            for (b = 0; b < GRP; b++)
            begin : gen_bit
                assign grp_and[g][b+1] = grp_and[g][b] & value[g*GRP+b];
                assign grp_inc[g][b]   = value[g*GRP+b] ^ grp_and[g][b];
            end
            assign grp_carry[g] = grp_and[g][GRP];

            if (g == 0)
            begin : gen_first
                // the lowest group always takes the +1.
                assign result[GRP-1:0] = grp_inc[0];
                assign carry_chain[0]  = grp_carry[0];
            end
            else
            begin : gen_select
                // carry in picks the incremented or the untouched group.
                assign result[g*GRP +: GRP] = carry_chain[g-1] ? grp_inc[g]
                                                               : value[g*GRP +: GRP];
                assign carry_chain[g] = carry_chain[g-1] & grp_carry[g];
            end
        end

        if (REM_LSB < WIDTH)
        begin : gen_rem
            // leftover top bits just add the final carry.
            assign result[WIDTH-1:REM_LSB] =
                value[WIDTH-1:REM_LSB] + (WIDTH - REM_LSB)'(carry_chain[GROUPS-1]);
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
    import mem_if_pkg::*;
(
    input  pc_t       pc,
    input  logic      redirect_enable,
    input  pc_t       redirect_address,
    output pc_t       next_pc,
    output mem_addr_t memory_interface_address
);

    word_index_t pc_word;
    word_index_t pc_word_inc;

    // drop the byte offset, the fetch is always word aligned.
    assign pc_word = pc[$bits(pc_t)-1:2];

    word_incrementer i_word_incrementer
    (
        .value  (pc_word),
        .result (pc_word_inc)
    );

    always_comb
    begin
        if (redirect_enable)
        begin
            next_pc = redirect_address;
        end
        else
        begin
            next_pc = {pc_word_inc, 2'b00};
        end
    end

    // the read always targets the current pc.
    assign memory_interface_address = pc;

endmodule

`default_nettype wire

/* hw/fetch_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_control
    import fetch_pkg::*;
    import mem_if_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      enable,
    input  logic      jump_branch_enable,
    input  pc_t       jump_branch_address,
    input  logic      memory_ready,
    input  mem_word_t memory_read_data,
    input  pc_t       next_pc,
    output pc_t       pc,
    output logic      redirect_enable,
    output pc_t       redirect_address,
    output logic      memory_interface_enable,
    output logic      instr_valid,
    output mem_word_t instr,
    output pc_t       instr_pc
);

    logic read_busy;
    logic pend_valid;
    pc_t  pend_addr;
    logic read_done;
    logic take_word;

    assign memory_interface_enable = read_busy;
    assign read_done               = read_busy & memory_ready;

    // a live pulse is newer than a held one, so it wins.
    assign redirect_enable  = jump_branch_enable | pend_valid;
    assign redirect_address = jump_branch_enable ? jump_branch_address : pend_addr;

    // the returned word is stale if any redirect is known by now.
    assign take_word = read_done & ~redirect_enable;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc          <= `FETCH_RESET_VECTOR;
            read_busy   <= 1'b0;
            pend_valid  <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            instr_valid <= take_word;
            if (read_busy)
            begin
                if (memory_ready)
                begin
                    pc         <= next_pc;
                    read_busy  <= 1'b0;
                    pend_valid <= 1'b0;
                end
                else if (jump_branch_enable)
                begin
                    // hold the target until the in-flight read returns.
                    pend_valid <= 1'b1;
                end
            end
            else
            begin
                if (jump_branch_enable)
                begin
                    pc <= next_pc;
                end
                read_busy <= enable;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (read_busy && !memory_ready && jump_branch_enable)
        begin
            pend_addr <= jump_branch_address;
        end
        if (take_word)
        begin
            instr    <= memory_read_data;
            instr_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
    import mem_if_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      enable,
    input  logic      jump_branch_enable,
    input  pc_t       jump_branch_address,
    input  logic      memory_ready,
    input  mem_word_t memory_read_data,
    output logic      memory_interface_enable,
    output mem_addr_t memory_interface_address,
    output mem_word_t instr,
    output pc_t       instr_pc,
    output logic      instr_valid
);

    pc_t  pc;
    pc_t  next_pc;
    logic redirect_enable;
    pc_t  redirect_address;

    fetch_control i_fetch_control
    (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .enable                  (enable),
        .jump_branch_enable      (jump_branch_enable),
        .jump_branch_address     (jump_branch_address),
        .memory_ready            (memory_ready),
        .memory_read_data        (memory_read_data),
        .next_pc                 (next_pc),
        .pc                      (pc),
        .redirect_enable         (redirect_enable),
        .redirect_address        (redirect_address),
        .memory_interface_enable (memory_interface_enable),
        .instr_valid             (instr_valid),
        .instr                   (instr),
        .instr_pc                (instr_pc)
    );

    fetch_unit i_fetch_unit
    (
        .pc                       (pc),
        .redirect_enable          (redirect_enable),
        .redirect_address         (redirect_address),
        .next_pc                  (next_pc),
        .memory_interface_address (memory_interface_address)
    );

endmodule

`default_nettype wire

/* tb/instr_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module instr_mem_model
    import mem_if_pkg::*;
#(
    parameter int unsigned SEED = 1
)
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      memory_interface_enable,
    input  mem_addr_t memory_interface_address,
    output logic      memory_ready,
    output mem_word_t memory_read_data
);

    // the stored word is its own address scrambled by a fixed key.
    localparam logic [`FETCH_WORD_BITS-1:0] DATA_KEY = 32'h5A5A_0F0F;

    int unsigned wait_left;
    logic        serving;

    initial
    begin
        void'($urandom(SEED));
        memory_ready     = 1'b0;
        memory_read_data = '0;
        serving          = 1'b0;
        wait_left        = 0;
        forever
        begin
            @(posedge clk);
            #2;
            memory_ready = 1'b0;
            if (!arst_n)
            begin
                serving = 1'b0;
            end
            else
            begin
                // a new request gets a latency of 1 to 4 cycles.
                if (memory_interface_enable && !serving)
                begin
                    serving   = 1'b1;
                    wait_left = $urandom_range(4, 1);
                end
                if (serving)
                begin
                    wait_left = wait_left - 1;
                    if (wait_left == 0)
                    begin
                        memory_ready     = 1'b1;
                        memory_read_data = memory_interface_address ^ DATA_KEY;
                        serving          = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*;
    import mem_if_pkg::*;
;

    localparam int NUM_ROWS = 8;

    logic      clk;
    logic      arst_n;
    logic      enable;
    logic      jump_branch_enable;
    pc_t       jump_branch_address;
    logic      memory_ready;
    mem_word_t memory_read_data;
    logic      memory_interface_enable;
    mem_addr_t memory_interface_address;
    mem_word_t instr;
    pc_t       instr_pc;
    logic      instr_valid;

    // each row gives accepts, redirect flag and target, mid-read flag and enable-low gap.
    int   row_count  [NUM_ROWS] = '{3, 4, 3, 2, 3, 2, 4, 3};
    logic row_redir  [NUM_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    pc_t  row_target [NUM_ROWS] = '{32'h0, 32'h0000_1000, 32'h0000_2040, 32'hFFFF_FFF8,
                                    32'h0000_0FFC, 32'h0, 32'h0000_0300, 32'h0};
    logic row_mid    [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    int   row_gap    [NUM_ROWS] = '{0, 0, 0, 3, 0, 5, 2, 0};

    int        value_errors = 0;
    int        other_errors = 0;
    pc_t       exp_pc;
    logic      prev_mem_en = 1'b0;
    mem_addr_t prev_addr;

    fetch_top i_fetch_top
    (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .enable                   (enable),
        .jump_branch_enable       (jump_branch_enable),
        .jump_branch_address      (jump_branch_address),
        .memory_ready             (memory_ready),
        .memory_read_data         (memory_read_data),
        .memory_interface_enable  (memory_interface_enable),
        .memory_interface_address (memory_interface_address),
        .instr                    (instr),
        .instr_pc                 (instr_pc),
        .instr_valid              (instr_valid)
    );

    instr_mem_model #(.SEED(63570)) i_instr_mem_model
    (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .memory_interface_enable  (memory_interface_enable),
        .memory_interface_address (memory_interface_address),
        .memory_ready             (memory_ready),
        .memory_read_data         (memory_read_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input mem_word_t expected,
                              input mem_word_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t expected,
                              input mem_addr_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // inputs change 2 ns after the rising edge when outputs have settled.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic accept_instr();
        do
        begin
            next_cycle();
        end
        while (instr_valid !== 1'b1);
        check_pc("instr_pc", exp_pc, instr_pc);
        check_word("instr", exp_pc ^ 32'h5A5A_0F0F, instr);
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic pulse_redirect(input pc_t target);
        jump_branch_enable  = 1'b1;
        jump_branch_address = target;
        next_cycle();
        jump_branch_enable  = 1'b0;
        exp_pc              = target;
    endtask

    task automatic redirect_idle(input pc_t target);
        if (memory_interface_enable)
        begin
            $display("a read was still outstanding when an idle redirect was due at %0t ns",
                     $time);
            other_errors++;
        end
        pulse_redirect(target);
    endtask

    // the word at exp_pc is in flight and must never be delivered.
    task automatic redirect_mid_read(input pc_t target);
        while (!memory_interface_enable)
        begin
            next_cycle();
        end
        pulse_redirect(target);
    endtask

    task automatic enable_gap(input int cycles);
        while (!memory_interface_enable)
        begin
            next_cycle();
        end
        enable = 1'b0;
        accept_instr();
        repeat (cycles)
        begin
            next_cycle();
            check_flag("memory_interface_enable", 1'b0, memory_interface_enable);
            check_flag("instr_valid", 1'b0, instr_valid);
        end
        enable = 1'b1;
    endtask

    always @(negedge clk)
    begin
        if (arst_n && memory_interface_enable && prev_mem_en)
        begin
            check_addr("memory_interface_address", prev_addr, memory_interface_address);
        end
        prev_mem_en = memory_interface_enable;
        prev_addr   = memory_interface_address;
    end

    initial
    begin
        int r;
        arst_n              = 1'b0;
        enable              = 1'b1;
        jump_branch_enable  = 1'b0;
        jump_branch_address = '0;
        exp_pc              = `FETCH_RESET_VECTOR;
        repeat (16)
        begin
            next_cycle();
            check_flag("memory_interface_enable", 1'b0, memory_interface_enable);
            check_flag("instr_valid", 1'b0, instr_valid);
        end
        arst_n = 1'b1;
        for (r = 0; r < NUM_ROWS; r++)
        begin
            repeat (row_count[r])
            begin
                accept_instr();
            end
            if (row_gap[r] > 0)
            begin
                enable_gap(row_gap[r]);
            end
            if (row_redir[r])
            begin
                if (row_mid[r])
                begin
                    redirect_mid_read(row_target[r]);
                end
                else
                begin
                    redirect_idle(row_target[r]);
                end
            end
        end
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    // budget of 6 cycles per accepted word or gap cycle plus slack for reset.
    initial
    begin
        int cycles;
        int r;
        cycles = 0;
        for (r = 0; r < NUM_ROWS; r++)
        begin
            cycles = cycles + row_count[r] + row_gap[r];
        end
        cycles = cycles * 6 + 200;
        repeat (cycles) @(posedge clk);
        $display("timeout: the fetch stage stopped delivering instructions after %0d cycles",
                 cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/mem_if_pkg.sv
hw/fetch_pkg.sv
hw/word_incrementer.sv
hw/fetch_unit.sv
hw/fetch_control.sv
hw/fetch_top.sv
tb/instr_mem_model.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module fetch_tb -f list.f -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
else
    exit 1
fi
